// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= tbRvCore
FILELIST  ?= vlog.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: tb/rvCore_assertions.sv
`timescale 1ns/1ps

module rvCore_assertions
    import rvPkg::*;
#(
    parameter word_t resultBase = 32'h0000_0200
)
(
    input logic  clk,
    input logic  rst,
    input logic  cyc,
    input logic  stb,
    input logic  we,
    input logic  ack,
    input word_t adr,
    input word_t datW,
    input logic  halted
);

    // Hand-computed results, one per word from resultBase
    localparam int NUM_RESULTS = 18;
    localparam word_t EXPECTED [NUM_RESULTS] = '{
        32'h0000_0007, 32'hFFFF_FFEF, 32'hFFFF_FFF7, 32'hFFFF_FFFF,
        32'h0000_0008, 32'h0000_0001, 32'h0000_0000, 32'h0000_C000,
        32'h000F_FFFF, 32'hFFFF_FFFF, 32'h1234_5000, 32'h0000_1060,
        32'h0000_006B, 32'h0000_0000, 32'h0000_0006, 32'h0000_00E4,
        32'h0000_00F4, 32'h0000_0006
    };

    int    failCount = 0;
    int    storeCount;
    logic  fetchSeen;
    word_t slot;

    // Word slot of the current store
    assign slot = (adr - resultBase) >> 2;

    // Addresses jumped over by taken branches and jumps
    function automatic logic isSkipped(input word_t a);
        case (a)
            32'h80, 32'h90, 32'hA0, 32'hB0, 32'hC0, 32'hD0, 32'hE4, 32'hF4:
                return 1'b1;
            default:
                return 1'b0;
        endcase
    endfunction

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            storeCount <= 0;
            fetchSeen  <= 1'b0;
        end
        else
        begin
            if (stb && we && ack)
            begin
                storeCount <= storeCount + 1;
            end
            if (stb)
            begin
                fetchSeen <= 1'b1;
            end
        end
    end

    // Bus idle while in reset
    idleInReset: assert property (@(posedge clk) rst |-> (!cyc && !stb))
        else begin failCount++; $error("Bus active during reset"); end

    strobeInCycle: assert property (@(posedge clk) disable iff (rst) stb |-> cyc)
        else begin failCount++; $error("stb high without cyc"); end

    // Request held steady until ack
    heldUntilAck: assert property (@(posedge clk) disable iff (rst)
        (stb && !ack) |=> ($stable(adr) && $stable(we) && $stable(datW)))
        else begin failCount++; $error("Bus request changed before ack"); end

    firstFetch: assert property (@(posedge clk) disable iff (rst)
        (stb && !fetchSeen) |-> (adr == RESET_PC))
        else begin
            failCount++;
            $error("ERROR firstFetch expected %h actual %h", RESET_PC, adr);
        end

    storedValue: assert property (@(posedge clk) disable iff (rst)
        (stb && we && ack) |-> (slot < NUM_RESULTS && datW == EXPECTED[slot]))
        else begin
            failCount++;
            $error("ERROR store[%0d] expected %h actual %h", slot,
                   (slot < NUM_RESULTS) ? EXPECTED[slot] : 32'hx, datW);
        end

    noSkippedFetch: assert property (@(posedge clk) disable iff (rst)
        (stb && !we) |-> !isSkipped(adr))
        else begin failCount++; $error("Read from skipped address %h", adr); end

    // Every result slot written once before the halt
    allStored: assert property (@(posedge clk) disable iff (rst)
        $rose(halted) |-> (storeCount == NUM_RESULTS))
        else begin
            failCount++;
            $error("ERROR storeCount expected %0d actual %0d", NUM_RESULTS, storeCount);
        end

    haltSticky: assert property (@(posedge clk) disable iff (rst) halted |=> halted)
        else begin failCount++; $error("halted dropped before reset"); end

    quietAfterHalt: assert property (@(posedge clk) disable iff (rst) halted |-> !stb)
        else begin failCount++; $error("Bus cycle started after halt"); end

endmodule

// File: tb/tbRvCore.sv
`timescale 1ns/1ps

module tbRvCore
    import rvPkg::*;
;

    localparam word_t RESULT_BASE = 32'h0000_0200;
    localparam int PROG_LEN = 65;
    // Two bus cycles at three wait states, plus decode, execute, writeback
    localparam int WORST_PER_INSTR = 2 * (4 + 3) + 3 + 4;
    localparam int TIMEOUT_CYCLES = 10 + PROG_LEN * WORST_PER_INSTR + 200;

    logic  clk;
    logic  rst;
    logic  ack;
    word_t datR;
    logic  cyc;
    logic  stb;
    logic  we;
    word_t adr;
    word_t datW;
    logic  halted;

    word_t mem [256];
    int    loadIdx;
    logic  busy;
    int    waitCnt;

    rvCore i_rvCore (
        .clk    (clk),
        .rst    (rst),
        .ack    (ack),
        .datR   (datR),
        .cyc    (cyc),
        .stb    (stb),
        .we     (we),
        .adr    (adr),
        .datW   (datW),
        .halted (halted)
    );

    bind rvCore rvCore_assertions rvCoreChecks (.*);

    // Instruction encoders
    function automatic word_t opImm(input logic [2:0] f3, input int rd, input int rs1,
                                    input int imm);
        word_t i;
        i = imm;
        return {i[11:0], 5'(rs1), f3, 5'(rd), 7'b0010011};
    endfunction

    function automatic word_t opReg(input logic [6:0] f7, input logic [2:0] f3,
                                    input int rd, input int rs1, input int rs2);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
    endfunction

    function automatic word_t loadWord(input int rd, input int rs1, input int imm);
        word_t i;
        i = imm;
        return {i[11:0], 5'(rs1), 3'b010, 5'(rd), 7'b0000011};
    endfunction

    function automatic word_t storeWord(input int rs2, input int rs1, input int imm);
        word_t i;
        i = imm;
        return {i[11:5], 5'(rs2), 5'(rs1), 3'b010, i[4:0], 7'b0100011};
    endfunction

    function automatic word_t branch(input logic [2:0] f3, input int rs1, input int rs2,
                                     input int imm);
        word_t i;
        i = imm;
        return {i[12], i[10:5], 5'(rs2), 5'(rs1), f3, i[4:1], i[11], 7'b1100011};
    endfunction

    function automatic word_t upper(input logic [6:0] op, input int rd, input int imm20);
        word_t i;
        i = imm20;
        return {i[19:0], 5'(rd), op};
    endfunction

    function automatic word_t jump(input int rd, input int imm);
        word_t i;
        i = imm;
        return {i[20], i[10:1], i[11], i[19:12], 5'(rd), 7'b1101111};
    endfunction

    function automatic word_t jumpReg(input int rd, input int rs1, input int imm);
        word_t i;
        i = imm;
        return {i[11:0], 5'(rs1), 3'b000, 5'(rd), 7'b1100111};
    endfunction

    task automatic place(input word_t w);
        mem[loadIdx] = w;
        loadIdx++;
    endtask

    // Store a register into result slot k
    task automatic result(input int rs2, input int k);
        place(storeWord(rs2, 0, RESULT_BASE + 4 * k));
    endtask

    // Taken branch over a poison add, then not-taken into a count
    // Count is built on cntSrc, x0 starts it fresh
    task automatic branchPair(input logic [2:0] f3, input int ta, input int tb,
                              input int na, input int nb, input int cntSrc);
        place(branch(f3, ta, tb, 8));
        place(opImm(3'b000, 16, 16, 100));
        place(branch(f3, na, nb, 8));
        place(opImm(3'b000, 16, cntSrc, 1));
    endtask

    task automatic loadProgram();
        for (int i = 0; i < 256; i++)
        begin
            mem[i] = 32'hA5A5_0000 ^ (i * 32'h0001_0101);
        end
        loadIdx = 0;
        // Operands x1 = -5, x2 = 12
        place(opImm(3'b000, 1, 0, -5));
        place(opImm(3'b000, 2, 0, 12));
        place(opReg(7'h00, 3'b000, 3, 1, 2));
        result(3, 0);
        place(opReg(7'h20, 3'b000, 4, 1, 2));
        result(4, 1);
        place(opReg(7'h00, 3'b100, 5, 1, 2));
        result(5, 2);
        place(opReg(7'h00, 3'b110, 6, 1, 2));
        result(6, 3);
        place(opReg(7'h00, 3'b111, 7, 1, 2));
        result(7, 4);
        place(opReg(7'h00, 3'b010, 8, 1, 2));
        result(8, 5);
        place(opReg(7'h00, 3'b011, 9, 1, 2));
        result(9, 6);
        place(opReg(7'h00, 3'b001, 10, 2, 2));
        result(10, 7);
        place(opReg(7'h00, 3'b101, 11, 1, 2));
        result(11, 8);
        place(opReg(7'h20, 3'b101, 12, 1, 2));
        result(12, 9);
        place(upper(7'b0110111, 13, 20'h12345));
        result(13, 10);
        // AUIPC sits at 0x60
        place(upper(7'b0010111, 14, 20'h00001));
        result(14, 11);
        // Reload slot 0 and modify it
        place(loadWord(15, 0, RESULT_BASE));
        place(opImm(3'b000, 15, 15, 100));
        result(15, 12);
        place(opImm(3'b000, 0, 0, 55));
        result(0, 13);
        branchPair(3'b000, 3, 3, 1, 2, 0);
        branchPair(3'b001, 1, 2, 3, 3, 16);
        branchPair(3'b100, 1, 2, 2, 1, 16);
        branchPair(3'b101, 2, 1, 1, 2, 16);
        branchPair(3'b110, 2, 1, 1, 2, 16);
        branchPair(3'b111, 1, 2, 2, 1, 16);
        result(16, 14);
        // JAL at 0xE0 over one poison add
        place(jump(17, 8));
        place(opImm(3'b000, 16, 16, 100));
        result(17, 15);
        // JALR target with bit 0 set
        place(opImm(3'b000, 18, 0, 32'hF9));
        place(jumpReg(19, 18, 0));
        place(opImm(3'b000, 16, 16, 100));
        result(19, 16);
        result(16, 17);
        place(32'h0000_0073);
    endtask

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Memory with 0 to 3 random wait states
    always @(posedge clk)
    begin : memModel
        int w;
        if (rst)
        begin
            ack  <= 1'b0;
            busy <= 1'b0;
        end
        else
        begin
            ack <= 1'b0;
            if (stb && !ack)
            begin
                w = busy ? waitCnt : int'($urandom % 4);
                if (w == 0)
                begin
                    ack  <= 1'b1;
                    busy <= 1'b0;
                    datR <= mem[adr[9:2]];
                    if (we)
                    begin
                        mem[adr[9:2]] <= datW;
                    end
                end
                else
                begin
                    busy    <= 1'b1;
                    waitCnt <= w - 1;
                end
            end
        end
    end

    // Stop at the first assertion failure
    always @(negedge clk)
    begin
        if (i_rvCore.rvCoreChecks.failCount != 0)
        begin
            $display("Testbench failed");
            $fatal(1, "Assertion failure in the bus and result checker");
        end
    end

    initial
    begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Testbench failed");
        $fatal(1, "Watchdog expired before the core halted");
    end

    initial
    begin
        void'($urandom(32'h88a6));
        rst     = 1'b1;
        ack     = 1'b0;
        datR    = '0;
        busy    = 1'b0;
        waitCnt = 0;
        loadProgram();
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        wait (halted);
        // Idle bus after halt is checked meanwhile
        repeat (20) @(posedge clk);
        // Past the checker actions of the last edge
        #1;
        if (i_rvCore.rvCoreChecks.failCount == 0)
        begin
            $display("Testbench passed");
        end
        else
        begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: verilog/busArbiter.sv
`timescale 1ns/1ps

module busArbiter
    import rvPkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  m0Cyc,
    input  logic  m0Stb,
    input  word_t m0Adr,
    input  logic  m1Cyc,
    input  logic  m1Stb,
    input  logic  m1We,
    input  word_t m1Adr,
    input  word_t m1DatW,
    input  logic  ack,
    input  word_t datR,
    output logic  cyc,
    output logic  stb,
    output logic  we,
    output word_t adr,
    output word_t datW,
    output logic  m0Ack,
    output logic  m1Ack,
    output word_t m0DatR,
    output word_t m1DatR
);

    logic locked;
    logic grantQ;
    logic sel;

    // Held grant wins, otherwise load/store first
    assign sel = locked ? grantQ : m1Cyc;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            locked <= 1'b0;
            grantQ <= 1'b0;
        end
        else if (cyc && ack)
        begin
            // Release at the end of the granted cycle
            locked <= 1'b0;
        end
        else if (!locked && (m0Cyc || m1Cyc))
        begin
            locked <= 1'b1;
            grantQ <= sel;
        end
    end

    // Shared port mux, fetch side only reads
    assign cyc  = sel ? m1Cyc : m0Cyc;
    assign stb  = sel ? m1Stb : m0Stb;
    assign we   = sel ? m1We : 1'b0;
    assign adr  = sel ? m1Adr : m0Adr;
    assign datW = sel ? m1DatW : '0;

    // Response only to the granted master
    assign m0Ack  = ack && !sel;
    assign m1Ack  = ack && sel;
    assign m0DatR = sel ? '0 : datR;
    assign m1DatR = sel ? datR : '0;

endmodule

// File: verilog/execUnit.sv
`timescale 1ns/1ps

module execUnit
    import rvPkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  regIdx_t    rs1,
    input  regIdx_t    rs2,
    input  regIdx_t    rd,
    input  word_t      imm,
    input  aluOp_t     aluOp,
    input  logic       aluSrcImm,
    input  logic       regWrite,
    input  logic       memRead,
    input  logic       memWrite,
    input  logic       isBranch,
    input  logic       isJal,
    input  logic       isJalr,
    input  logic       isAuipc,
    input  logic       isEcall,
    input  logic [2:0] branchCond,
    input  word_t      pc,
    input  logic       fetchDone,
    input  logic       memDone,
    input  word_t      loadData,
    output logic       fetchReq,
    output logic       memReq,
    output logic       pcLoad,
    output word_t      pcNext,
    output word_t      memAddr,
    output word_t      storeData,
    output logic       halted
);

    coreState_t state;
    logic       reqSent;
    word_t      regs [32];
    word_t      rs1Val;
    word_t      rs2Val;
    word_t      opA;
    word_t      opB;
    word_t      aluA;
    word_t      aluB;
    word_t      aluRes;
    word_t      result;
    word_t      wbData;
    word_t      pcPlus4;
    logic       taken;
    logic       regWe;

    // Register file, x0 reads as zero
    assign rs1Val = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2Val = (rs2 == '0) ? '0 : regs[rs2];

    always_ff @(posedge clk)
    begin
        if (regWe)
        begin
            regs[rd] <= wbData;
        end
    end

    // ALU operands
    assign aluA    = isAuipc ? pc : opA;
    assign aluB    = aluSrcImm ? imm : opB;
    assign pcPlus4 = pc + 32'd4;

    always_comb
    begin
        case (aluOp)
            ALU_SUB:   aluRes = aluA - aluB;
            ALU_AND:   aluRes = aluA & aluB;
            ALU_OR:    aluRes = aluA | aluB;
            ALU_XOR:   aluRes = aluA ^ aluB;
            ALU_SLL:   aluRes = aluA << aluB[4:0];
            ALU_SRL:   aluRes = aluA >> aluB[4:0];
            ALU_SRA:   aluRes = $signed(aluA) >>> aluB[4:0];
            ALU_SLT:   aluRes = {31'b0, $signed(aluA) < $signed(aluB)};
            ALU_SLTU:  aluRes = {31'b0, aluA < aluB};
            ALU_PASSB: aluRes = aluB;
            default:   aluRes = aluA + aluB;
        endcase
    end

    // Branch compare on func3
    always_comb
    begin
        case (branchCond)
            3'b000:  taken = (opA == opB);
            3'b001:  taken = (opA != opB);
            3'b100:  taken = ($signed(opA) < $signed(opB));
            3'b101:  taken = ($signed(opA) >= $signed(opB));
            3'b110:  taken = (opA < opB);
            3'b111:  taken = (opA >= opB);
            default: taken = 1'b0;
        endcase
    end

    // Operand latch in DECODE, results in EXECUTE
    always_ff @(posedge clk)
    begin
        if (state == ST_DECODE)
        begin
            opA <= rs1Val;
            opB <= rs2Val;
        end
        if (state == ST_EXECUTE)
        begin
            // Jumps link the return address
            result    <= (isJal || isJalr) ? pcPlus4 : aluRes;
            memAddr   <= aluRes;
            storeData <= opB;
            if (isJalr)
            begin
                pcNext <= (opA + imm) & ~32'd1;
            end
            else if (isJal || (isBranch && taken))
            begin
                pcNext <= pc + imm;
            end
            else
            begin
                pcNext <= pcPlus4;
            end
        end
    end

    // Sequencing FSM
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state    <= ST_FETCH;
            reqSent  <= 1'b0;
            fetchReq <= 1'b0;
            memReq   <= 1'b0;
        end
        else
        begin
            fetchReq <= 1'b0;
            memReq   <= 1'b0;
            case (state)
                ST_FETCH:
                begin
                    // One request pulse, then wait for the word
                    if (!reqSent)
                    begin
                        fetchReq <= 1'b1;
                        reqSent  <= 1'b1;
                    end
                    else if (fetchDone)
                    begin
                        reqSent <= 1'b0;
                        state   <= ST_DECODE;
                    end
                end
                ST_DECODE:
                begin
                    state <= ST_EXECUTE;
                end
                ST_EXECUTE:
                begin
                    if (isEcall)
                    begin
                        state <= ST_HALT;
                    end
                    else if (memRead || memWrite)
                    begin
                        memReq <= 1'b1;
                        state  <= ST_MEMORY;
                    end
                    else
                    begin
                        state <= ST_WRITEBACK;
                    end
                end
                ST_MEMORY:
                begin
                    if (memDone)
                    begin
                        state <= ST_WRITEBACK;
                    end
                end
                ST_WRITEBACK:
                begin
                    state <= ST_FETCH;
                end
                default:
                begin
                    // HALT holds until reset
                    state <= ST_HALT;
                end
            endcase
        end
    end

    // Writeback and PC update in the same cycle
    assign wbData = memRead ? loadData : result;
    assign regWe  = (state == ST_WRITEBACK) && regWrite && (rd != '0);
    assign pcLoad = (state == ST_WRITEBACK);
    assign halted = (state == ST_HALT);

endmodule

// File: verilog/fetchUnit.sv
`timescale 1ns/1ps

module fetchUnit
    import rvPkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  fetchReq,
    input  logic  pcLoad,
    input  word_t pcNext,
    input  logic  ack,
    input  word_t datR,
    output word_t pc,
    output logic  fetchDone,
    output word_t instrOut,
    output logic  cyc,
    output logic  stb,
    output word_t adr
);

    // PC and bus cycle control
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            pc        <= RESET_PC;
            cyc       <= 1'b0;
            fetchDone <= 1'b0;
        end
        else
        begin
            fetchDone <= 1'b0;
            if (pcLoad)
            begin
                pc <= pcNext;
            end
            if (fetchReq)
            begin
                cyc <= 1'b1;
            end
            else if (cyc && ack)
            begin
                // Cycle ends here, word handed over next cycle
                cyc       <= 1'b0;
                fetchDone <= 1'b1;
            end
        end
    end

    // Fetched word
    always_ff @(posedge clk)
    begin
        if (cyc && ack)
        begin
            instrOut <= datR;
        end
    end

    // PC is held for the whole cycle
    assign stb = cyc;
    assign adr = pc;

endmodule

// File: verilog/instrDecode.sv
`timescale 1ns/1ps

module instrDecode
    import rvPkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       fetchDone,
    input  word_t      instrIn,
    output regIdx_t    rs1,
    output regIdx_t    rs2,
    output regIdx_t    rd,
    output word_t      imm,
    output aluOp_t     aluOp,
    output logic       aluSrcImm,
    output logic       regWrite,
    output logic       memRead,
    output logic       memWrite,
    output logic       isBranch,
    output logic       isJal,
    output logic       isJalr,
    output logic       isAuipc,
    output logic       isEcall,
    output logic [2:0] branchCond
);

    word_t   instr;
    opcode_t opcode;
    word_t   immI;
    word_t   immS;
    word_t   immB;
    word_t   immU;
    word_t   immJ;

    // Shared func3 decode for OP and OP-IMM
    // SUB only exists in the register form
    function automatic aluOp_t aluFromFunc3(input logic [2:0] f3, input logic alt,
                                            input logic regForm);
        aluOp_t op;
        case (f3)
            3'b000:  op = (alt && regForm) ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    // Instruction register, zero decodes as a no-op
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            instr <= '0;
        end
        else if (fetchDone)
        begin
            instr <= instrIn;
        end
    end

    // Fixed instruction fields
    assign opcode     = opcode_t'(instr[6:0]);
    assign rd         = instr[11:7];
    assign rs1        = instr[19:15];
    assign rs2        = instr[24:20];
    assign branchCond = instr[14:12];

    // Sign-extended immediates per format
    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign immU = {instr[31:12], 12'b0};
    assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb
    begin
        // Everything low unless the opcode is known
        imm       = '0;
        aluOp     = ALU_ADD;
        aluSrcImm = 1'b0;
        regWrite  = 1'b0;
        memRead   = 1'b0;
        memWrite  = 1'b0;
        isBranch  = 1'b0;
        isJal     = 1'b0;
        isJalr    = 1'b0;
        isAuipc   = 1'b0;
        isEcall   = 1'b0;
        case (opcode)
            OP_LUI:
            begin
                imm       = immU;
                aluOp     = ALU_PASSB;
                aluSrcImm = 1'b1;
                regWrite  = 1'b1;
            end
            OP_AUIPC:
            begin
                // PC replaces rs1 as operand A
                imm       = immU;
                aluSrcImm = 1'b1;
                regWrite  = 1'b1;
                isAuipc   = 1'b1;
            end
            OP_JAL:
            begin
                imm      = immJ;
                regWrite = 1'b1;
                isJal    = 1'b1;
            end
            OP_JALR:
            begin
                imm       = immI;
                aluSrcImm = 1'b1;
                regWrite  = 1'b1;
                isJalr    = 1'b1;
            end
            OP_BRANCH:
            begin
                imm      = immB;
                isBranch = 1'b1;
            end
            OP_LOAD:
            begin
                // Word access only, func3 not checked
                imm       = immI;
                aluSrcImm = 1'b1;
                regWrite  = 1'b1;
                memRead   = 1'b1;
            end
            OP_STORE:
            begin
                imm       = immS;
                aluSrcImm = 1'b1;
                memWrite  = 1'b1;
            end
            OP_OPIMM:
            begin
                // Shift amount sits in imm[4:0]
                imm       = immI;
                aluOp     = aluFromFunc3(instr[14:12], instr[30], 1'b0);
                aluSrcImm = 1'b1;
                regWrite  = 1'b1;
            end
            OP_OP:
            begin
                aluOp    = aluFromFunc3(instr[14:12], instr[30], 1'b1);
                regWrite = 1'b1;
            end
            OP_SYSTEM:
            begin
                // ECALL only, EBREAK falls through as a no-op
                isEcall = (instr[31:7] == '0);
            end
            default:
            begin
                imm = '0;
            end
        endcase
    end

endmodule

// File: verilog/loadStoreUnit.sv
`timescale 1ns/1ps

module loadStoreUnit
    import rvPkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  memReq,
    input  logic  memWrite,
    input  word_t memAddr,
    input  word_t storeData,
    input  logic  ack,
    input  word_t datR,
    output logic  memDone,
    output word_t loadData,
    output logic  cyc,
    output logic  stb,
    output logic  we,
    output word_t adr,
    output word_t datW
);

    // Cycle control and direction
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            cyc     <= 1'b0;
            we      <= 1'b0;
            memDone <= 1'b0;
        end
        else
        begin
            memDone <= 1'b0;
            if (memReq)
            begin
                cyc <= 1'b1;
                we  <= memWrite;
            end
            else if (cyc && ack)
            begin
                cyc     <= 1'b0;
                memDone <= 1'b1;
            end
        end
    end

    // Address and data held through the cycle
    always_ff @(posedge clk)
    begin
        if (memReq)
        begin
            adr  <= memAddr;
            datW <= storeData;
        end
        if (cyc && ack && !we)
        begin
            loadData <= datR;
        end
    end

    assign stb = cyc;

endmodule

// File: verilog/rvCore.sv
`timescale 1ns/1ps

module rvCore
    import rvPkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  ack,
    input  word_t datR,
    output logic  cyc,
    output logic  stb,
    output logic  we,
    output word_t adr,
    output word_t datW,
    output logic  halted
);

    // Decoded instruction
    regIdx_t    rs1;
    regIdx_t    rs2;
    regIdx_t    rd;
    word_t      imm;
    aluOp_t     aluOp;
    logic       aluSrcImm;
    logic       regWrite;
    logic       memRead;
    logic       memWrite;
    logic       isBranch;
    logic       isJal;
    logic       isJalr;
    logic       isAuipc;
    logic       isEcall;
    logic [2:0] branchCond;

    // Sequencing
    logic  fetchReq;
    logic  fetchDone;
    logic  memReq;
    logic  memDone;
    logic  pcLoad;
    word_t pc;
    word_t pcNext;
    word_t instr;
    word_t memAddr;
    word_t storeData;
    word_t loadData;

    // Fetch master
    logic  fetchCyc;
    logic  fetchStb;
    word_t fetchAdr;
    logic  fetchAck;
    word_t fetchDatR;

    // Load/store master
    logic  lsuCyc;
    logic  lsuStb;
    logic  lsuWe;
    word_t lsuAdr;
    word_t lsuDatW;
    logic  lsuAck;
    word_t lsuDatR;

    instrDecode i_instrDecode (
        .clk        (clk),
        .rst        (rst),
        .fetchDone  (fetchDone),
        .instrIn    (instr),
        .rs1        (rs1),
        .rs2        (rs2),
        .rd         (rd),
        .imm        (imm),
        .aluOp      (aluOp),
        .aluSrcImm  (aluSrcImm),
        .regWrite   (regWrite),
        .memRead    (memRead),
        .memWrite   (memWrite),
        .isBranch   (isBranch),
        .isJal      (isJal),
        .isJalr     (isJalr),
        .isAuipc    (isAuipc),
        .isEcall    (isEcall),
        .branchCond (branchCond)
    );

    fetchUnit i_fetchUnit (
        .clk       (clk),
        .rst       (rst),
        .fetchReq  (fetchReq),
        .pcLoad    (pcLoad),
        .pcNext    (pcNext),
        .ack       (fetchAck),
        .datR      (fetchDatR),
        .pc        (pc),
        .fetchDone (fetchDone),
        .instrOut  (instr),
        .cyc       (fetchCyc),
        .stb       (fetchStb),
        .adr       (fetchAdr)
    );

    execUnit i_execUnit (
        .clk        (clk),
        .rst        (rst),
        .rs1        (rs1),
        .rs2        (rs2),
        .rd         (rd),
        .imm        (imm),
        .aluOp      (aluOp),
        .aluSrcImm  (aluSrcImm),
        .regWrite   (regWrite),
        .memRead    (memRead),
        .memWrite   (memWrite),
        .isBranch   (isBranch),
        .isJal      (isJal),
        .isJalr     (isJalr),
        .isAuipc    (isAuipc),
        .isEcall    (isEcall),
        .branchCond (branchCond),
        .pc         (pc),
        .fetchDone  (fetchDone),
        .memDone    (memDone),
        .loadData   (loadData),
        .fetchReq   (fetchReq),
        .memReq     (memReq),
        .pcLoad     (pcLoad),
        .pcNext     (pcNext),
        .memAddr    (memAddr),
        .storeData  (storeData),
        .halted     (halted)
    );

    loadStoreUnit i_loadStoreUnit (
        .clk       (clk),
        .rst       (rst),
        .memReq    (memReq),
        .memWrite  (memWrite),
        .memAddr   (memAddr),
        .storeData (storeData),
        .ack       (lsuAck),
        .datR      (lsuDatR),
        .memDone   (memDone),
        .loadData  (loadData),
        .cyc       (lsuCyc),
        .stb       (lsuStb),
        .we        (lsuWe),
        .adr       (lsuAdr),
        .datW      (lsuDatW)
    );

    // Fetch on m0, load/store on m1
    busArbiter i_busArbiter (
        .clk    (clk),
        .rst    (rst),
        .m0Cyc  (fetchCyc),
        .m0Stb  (fetchStb),
        .m0Adr  (fetchAdr),
        .m1Cyc  (lsuCyc),
        .m1Stb  (lsuStb),
        .m1We   (lsuWe),
        .m1Adr  (lsuAdr),
        .m1DatW (lsuDatW),
        .ack    (ack),
        .datR   (datR),
        .cyc    (cyc),
        .stb    (stb),
        .we     (we),
        .adr    (adr),
        .datW   (datW),
        .m0Ack  (fetchAck),
        .m1Ack  (lsuAck),
        .m0DatR (fetchDatR),
        .m1DatR (lsuDatR)
    );

endmodule

// File: verilog/rvPkg.sv
package rvPkg;

    // Data and address word
    typedef logic [31:0] word_t;

    // Register file index
    typedef logic [4:0] regIdx_t;

    // RV32I major opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_OPIMM  = 7'b0010011,
        OP_OP     = 7'b0110011,
        OP_SYSTEM = 7'b1110011
    } opcode_t;

    // ALU operations
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        // Immediate straight through, for LUI
        ALU_PASSB
    } aluOp_t;

    // Core sequencing states
    typedef enum logic [2:0] {
        ST_FETCH,
        ST_DECODE,
        ST_EXECUTE,
        ST_MEMORY,
        ST_WRITEBACK,
        ST_HALT
    } coreState_t;

    // First fetch address after reset
    localparam word_t RESET_PC = 32'h0000_0000;

endpackage

// File: vlog.f
verilog/rvPkg.sv
verilog/instrDecode.sv
verilog/fetchUnit.sv
verilog/execUnit.sv
verilog/loadStoreUnit.sv
verilog/busArbiter.sv
verilog/rvCore.sv
tb/rvCore_assertions.sv
tb/tbRvCore.sv
